/* exec_pkg.sv */
package exec_pkg;

    // Integer register width fixed by RV32I
    localparam int xlen = 32;

    ////////////////////
    // ALU operations
    ////////////////////
    typedef enum logic [4:0] {
        alu_add    = 5'd0,
        alu_sub    = 5'd1,
        alu_sll    = 5'd2,
        alu_slt    = 5'd3,
        alu_sltu   = 5'd4,
        alu_xor    = 5'd5,
        alu_srl    = 5'd6,
        alu_sra    = 5'd7,
        alu_or     = 5'd8,
        alu_and    = 5'd9,
        alu_pass_b = 5'd10,
        alu_link   = 5'd11,
        alu_beq    = 5'd12,
        alu_bne    = 5'd13,
        alu_blt    = 5'd14,
        alu_bge    = 5'd15,
        alu_bltu   = 5'd16,
        alu_bgeu   = 5'd17
    } alu_op_t;

    ////////////////////
    // Memory access codes
    ////////////////////
    typedef enum logic [2:0] {
        ld_none = 3'd0,
        ld_lb   = 3'd1,
        ld_lh   = 3'd2,
        ld_lw   = 3'd3,
        ld_lbu  = 3'd4,
        ld_lhu  = 3'd5
    } load_t;

    typedef enum logic [1:0] {
        st_none = 2'd0,
        st_sb   = 2'd1,
        st_sh   = 2'd2,
        st_sw   = 2'd3
    } store_t;

    // Operand source selects, nearest slot first after the alternate
    typedef enum logic [2:0] {
        fwd_reg = 3'd0,
        fwd_alt = 3'd1,
        fwd_dm1 = 3'd2,
        fwd_dm2 = 3'd3,
        fwd_dm3 = 3'd4,
        fwd_wb  = 3'd5
    } fwd_sel_t;

endpackage

/* forward_unit.sv */
`timescale 1ns/10ps

module forward_unit (
    input  logic [4:0]         rs1_address,
    input  logic [4:0]         rs2_address,
    input  logic               use_pc,
    input  logic               use_imm,
    input  logic [4:0]         dm1_rd_address,
    input  logic [4:0]         dm2_rd_address,
    input  logic [4:0]         dm3_rd_address,
    input  logic [4:0]         wb_rd_address,
    input  logic               dm1_write_enable,
    input  logic               dm2_write_enable,
    input  logic               dm3_write_enable,
    input  logic               wb_write_enable,
    output exec_pkg::fwd_sel_t in1_select,
    output exec_pkg::fwd_sel_t in2_select
);

    import exec_pkg::*;

    // Priority pick for one operand
    function automatic fwd_sel_t pick_source(
        input logic [4:0] rs,
        input logic       use_alt
    );
        fwd_sel_t sel;
        sel = fwd_reg;
        if (use_alt)
        begin
            sel = fwd_alt;
        end
        else if (rs != 5'd0)
        begin
            // Youngest producer wins
            if (dm1_write_enable && dm1_rd_address == rs)
                sel = fwd_dm1;
            else if (dm2_write_enable && dm2_rd_address == rs)
                sel = fwd_dm2;
            else if (dm3_write_enable && dm3_rd_address == rs)
                sel = fwd_dm3;
            else if (wb_write_enable && wb_rd_address == rs)
                sel = fwd_wb;
        end
        return sel;
    endfunction

    always_comb
    begin
        in1_select = pick_source(rs1_address, use_pc);
        in2_select = pick_source(rs2_address, use_imm);
    end

endmodule

/* alu.sv */
`timescale 1ns/10ps

module alu (
    input  logic [exec_pkg::xlen-1:0] in1,
    input  logic [exec_pkg::xlen-1:0] in2,
    input  exec_pkg::alu_op_t         op,
    output logic [exec_pkg::xlen-1:0] result,
    output logic                      branch_taken
);

    import exec_pkg::*;

    logic [4:0] shamt;
    logic       eq;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = in2[4:0];
    assign eq          = (in1 == in2);
    assign lt_signed   = ($signed(in1) < $signed(in2));
    assign lt_unsigned = (in1 < in2);

    ////////////////////
    // Result path
    ////////////////////
    always_comb
    begin
        result = '0;
        case (op)
            alu_add:    result = in1 + in2;
            alu_sub:    result = in1 - in2;
            alu_sll:    result = in1 << shamt;
            alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:    result = in1 ^ in2;
            alu_srl:    result = in1 >> shamt;
            alu_sra:    result = $unsigned($signed(in1) >>> shamt);
            alu_or:     result = in1 | in2;
            alu_and:    result = in1 & in2;
            // LUI immediate
            alu_pass_b: result = in2;
            // Return address for JAL and JALR
            alu_link:   result = in1 + xlen'(4);
            default:    result = '0;
        endcase
    end

    ////////////////////
    // Branch compare
    ////////////////////
    always_comb
    begin
        branch_taken = 1'b0;
        case (op)
            alu_beq:  branch_taken = eq;
            alu_bne:  branch_taken = !eq;
            alu_blt:  branch_taken = lt_signed;
            alu_bge:  branch_taken = !lt_signed;
            alu_bltu: branch_taken = lt_unsigned;
            alu_bgeu: branch_taken = !lt_unsigned;
            default:  branch_taken = 1'b0;
        endcase
    end

endmodule

/* execution_stage.sv */
`timescale 1ns/10ps

module execution_stage (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  logic                      stall,
    input  logic                      clear,
    input  logic [exec_pkg::xlen-1:0] pc,
    input  logic [exec_pkg::xlen-1:0] rs1_data,
    input  logic [exec_pkg::xlen-1:0] rs2_data,
    input  logic [exec_pkg::xlen-1:0] imm,
    input  logic [exec_pkg::xlen-1:0] dm2_data,
    input  logic [exec_pkg::xlen-1:0] dm3_data,
    input  logic [exec_pkg::xlen-1:0] wb_data,
    input  exec_pkg::fwd_sel_t        in1_select,
    input  exec_pkg::fwd_sel_t        in2_select,
    input  exec_pkg::alu_op_t         alu_op,
    input  exec_pkg::load_t           load,
    input  exec_pkg::store_t          store,
    input  logic [4:0]                rd_address_in,
    input  logic                      rd_write_enable_in,
    output logic                      branch_taken,
    output logic [exec_pkg::xlen-1:0] dm1_result,
    output logic [exec_pkg::xlen-1:0] dm1_store_data,
    output exec_pkg::load_t           dm1_load,
    output exec_pkg::store_t          dm1_store,
    output logic [4:0]                dm1_rd_address,
    output logic                      dm1_write_enable
);

    import exec_pkg::*;

    logic [xlen-1:0] alu_in1;
    logic [xlen-1:0] alu_in2;
    logic [xlen-1:0] store_value;
    logic [xlen-1:0] alu_result;

    // Six-way operand source; alt is PC or immediate depending on the side
    function automatic logic [xlen-1:0] operand_mux(
        input fwd_sel_t        sel,
        input logic [xlen-1:0] reg_value,
        input logic [xlen-1:0] alt_value
    );
        logic [xlen-1:0] value;
        case (sel)
            fwd_alt: value = alt_value;
            fwd_dm1: value = dm1_result;
            fwd_dm2: value = dm2_data;
            fwd_dm3: value = dm3_data;
            fwd_wb:  value = wb_data;
            default: value = reg_value;
        endcase
        return value;
    endfunction

    always_comb
    begin
        alu_in1     = operand_mux(in1_select, rs1_data, pc);
        alu_in2     = operand_mux(in2_select, rs2_data, imm);
        // Store data takes the register side of operand 2
        store_value = operand_mux(in2_select, rs2_data, rs2_data);
    end

    alu alu_i (
        .in1          (alu_in1),
        .in2          (alu_in2),
        .op           (alu_op),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    ////////////////////
    // DM1 register
    ////////////////////
    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dm1_result       <= '0;
            dm1_store_data   <= '0;
            dm1_load         <= ld_none;
            dm1_store        <= st_none;
            dm1_rd_address   <= '0;
            dm1_write_enable <= 1'b0;
        end
        else if (!stall)
        begin
            if (clear)
            begin
                // Bubble
                dm1_result       <= '0;
                dm1_store_data   <= '0;
                dm1_load         <= ld_none;
                dm1_store        <= st_none;
                dm1_rd_address   <= '0;
                dm1_write_enable <= 1'b0;
            end
            else
            begin
                dm1_result       <= alu_result;
                dm1_store_data   <= store_value;
                dm1_load         <= load;
                dm1_store        <= store;
                dm1_rd_address   <= rd_address_in;
                dm1_write_enable <= rd_write_enable_in;
            end
        end
    end

endmodule

/* mem_pipeline.sv */
`timescale 1ns/10ps

module mem_pipeline #(
    parameter int mem_words = 256
) (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  logic                      stall,
    input  logic [exec_pkg::xlen-1:0] dm1_result,
    input  logic [exec_pkg::xlen-1:0] dm1_store_data,
    input  exec_pkg::load_t           dm1_load,
    input  exec_pkg::store_t          dm1_store,
    input  logic [4:0]                dm1_rd_address,
    input  logic                      dm1_write_enable,
    output logic [4:0]                dm2_rd_address,
    output logic                      dm2_write_enable,
    output logic [exec_pkg::xlen-1:0] dm2_data,
    output logic [4:0]                dm3_rd_address,
    output logic                      dm3_write_enable,
    output logic [exec_pkg::xlen-1:0] dm3_data,
    output logic [4:0]                wb_rd_address,
    output logic                      wb_write_enable,
    output logic [exec_pkg::xlen-1:0] wb_data
);

    import exec_pkg::*;

    localparam int index_bits = $clog2(mem_words);

    logic [xlen-1:0]       mem [0:mem_words-1];
    logic [index_bits-1:0] word_index;
    logic [3:0]            byte_enable;
    logic [xlen-1:0]       write_word;
    logic [xlen-1:0]       dm2_word;
    logic [xlen-1:0]       dm3_word;
    logic [xlen-1:0]       dm3_result;
    load_t                 dm2_load;
    load_t                 dm3_load;

    // Select lanes by the low address bits and extend
    function automatic logic [xlen-1:0] extend_load(
        input load_t           code,
        input logic [xlen-1:0] word,
        input logic [1:0]      offset
    );
        logic [xlen-1:0] shifted;
        shifted = word >> {offset, 3'b000};
        case (code)
            ld_lb:   return {{(xlen-8){shifted[7]}}, shifted[7:0]};
            ld_lh:   return {{(xlen-16){shifted[15]}}, shifted[15:0]};
            ld_lbu:  return {{(xlen-8){1'b0}}, shifted[7:0]};
            ld_lhu:  return {{(xlen-16){1'b0}}, shifted[15:0]};
            default: return word;
        endcase
    endfunction

    ////////////////////
    // Data memory
    ////////////////////
    // Upper address bits dropped
    assign word_index = dm1_result[index_bits+1:2];

    always_comb
    begin
        byte_enable = 4'b0000;
        write_word  = dm1_store_data;
        case (dm1_store)
            st_sb:
            begin
                byte_enable = 4'b0001 << dm1_result[1:0];
                write_word  = {4{dm1_store_data[7:0]}};
            end
            st_sh:
            begin
                byte_enable = dm1_result[1] ? 4'b1100 : 4'b0011;
                write_word  = {2{dm1_store_data[15:0]}};
            end
            st_sw:   byte_enable = 4'b1111;
            default: byte_enable = 4'b0000;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (!stall)
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (byte_enable[lane])
                    mem[word_index][lane*8 +: 8] <= write_word[lane*8 +: 8];
            end
        end
    end

    ////////////////////
    // DM2, DM3 and WB registers
    ////////////////////
    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dm2_rd_address   <= '0;
            dm2_write_enable <= 1'b0;
            dm2_data         <= '0;
            dm2_load         <= ld_none;
            dm2_word         <= '0;
            dm3_rd_address   <= '0;
            dm3_write_enable <= 1'b0;
            dm3_result       <= '0;
            dm3_load         <= ld_none;
            dm3_word         <= '0;
            wb_rd_address    <= '0;
            wb_write_enable  <= 1'b0;
            wb_data          <= '0;
        end
        else if (!stall)
        begin
            dm2_rd_address   <= dm1_rd_address;
            dm2_write_enable <= dm1_write_enable;
            dm2_data         <= dm1_result;
            dm2_load         <= dm1_load;
            // Word read on the same edge as a store write
            dm2_word         <= mem[word_index];
            dm3_rd_address   <= dm2_rd_address;
            dm3_write_enable <= dm2_write_enable;
            dm3_result       <= dm2_data;
            dm3_load         <= dm2_load;
            dm3_word         <= dm2_word;
            wb_rd_address    <= dm3_rd_address;
            wb_write_enable  <= dm3_write_enable;
            wb_data          <= dm3_data;
        end
    end

    // Extended load data leaves DM3
    // Slots one and two behind a load only see its address
    assign dm3_data = (dm3_load != ld_none)
                    ? extend_load(dm3_load, dm3_word, dm3_result[1:0])
                    : dm3_result;

endmodule

/* exec_top.sv */
`timescale 1ns/10ps

module exec_top #(
    parameter int mem_words = 256
) (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  logic                      stall,
    input  logic                      clear,
    input  logic [exec_pkg::xlen-1:0] pc,
    input  logic [exec_pkg::xlen-1:0] imm,
    input  logic [exec_pkg::xlen-1:0] rs1_data,
    input  logic [exec_pkg::xlen-1:0] rs2_data,
    input  logic [4:0]                rs1_address,
    input  logic [4:0]                rs2_address,
    input  logic                      use_pc,
    input  logic                      use_imm,
    input  exec_pkg::alu_op_t         alu_op,
    input  exec_pkg::load_t           load,
    input  exec_pkg::store_t          store,
    input  logic [4:0]                rd_address,
    input  logic                      rd_write_enable,
    output logic                      branch_taken,
    output logic [4:0]                wb_rd_address,
    output logic                      wb_write_enable,
    output logic [exec_pkg::xlen-1:0] wb_data
);

    import exec_pkg::*;

    fwd_sel_t        in1_select;
    fwd_sel_t        in2_select;
    logic [xlen-1:0] dm1_result;
    logic [xlen-1:0] dm1_store_data;
    load_t           dm1_load;
    store_t          dm1_store;
    logic [4:0]      dm1_rd_address;
    logic            dm1_write_enable;
    logic [4:0]      dm2_rd_address;
    logic            dm2_write_enable;
    logic [xlen-1:0] dm2_data;
    logic [4:0]      dm3_rd_address;
    logic            dm3_write_enable;
    logic [xlen-1:0] dm3_data;

    forward_unit forward_unit_i (
        .rs1_address      (rs1_address),
        .rs2_address      (rs2_address),
        .use_pc           (use_pc),
        .use_imm          (use_imm),
        .dm1_rd_address   (dm1_rd_address),
        .dm2_rd_address   (dm2_rd_address),
        .dm3_rd_address   (dm3_rd_address),
        .wb_rd_address    (wb_rd_address),
        .dm1_write_enable (dm1_write_enable),
        .dm2_write_enable (dm2_write_enable),
        .dm3_write_enable (dm3_write_enable),
        .wb_write_enable  (wb_write_enable),
        .in1_select       (in1_select),
        .in2_select       (in2_select)
    );

    execution_stage execution_stage_i (
        .CLK                (CLK),
        .rst_n              (rst_n),
        .stall              (stall),
        .clear              (clear),
        .pc                 (pc),
        .rs1_data           (rs1_data),
        .rs2_data           (rs2_data),
        .imm                (imm),
        .dm2_data           (dm2_data),
        .dm3_data           (dm3_data),
        .wb_data            (wb_data),
        .in1_select         (in1_select),
        .in2_select         (in2_select),
        .alu_op             (alu_op),
        .load               (load),
        .store              (store),
        .rd_address_in      (rd_address),
        .rd_write_enable_in (rd_write_enable),
        .branch_taken       (branch_taken),
        .dm1_result         (dm1_result),
        .dm1_store_data     (dm1_store_data),
        .dm1_load           (dm1_load),
        .dm1_store          (dm1_store),
        .dm1_rd_address     (dm1_rd_address),
        .dm1_write_enable   (dm1_write_enable)
    );

    mem_pipeline #(.mem_words(mem_words)) mem_pipeline_i (
        .CLK              (CLK),
        .rst_n            (rst_n),
        .stall            (stall),
        .dm1_result       (dm1_result),
        .dm1_store_data   (dm1_store_data),
        .dm1_load         (dm1_load),
        .dm1_store        (dm1_store),
        .dm1_rd_address   (dm1_rd_address),
        .dm1_write_enable (dm1_write_enable),
        .dm2_rd_address   (dm2_rd_address),
        .dm2_write_enable (dm2_write_enable),
        .dm2_data         (dm2_data),
        .dm3_rd_address   (dm3_rd_address),
        .dm3_write_enable (dm3_write_enable),
        .dm3_data         (dm3_data),
        .wb_rd_address    (wb_rd_address),
        .wb_write_enable  (wb_write_enable),
        .wb_data          (wb_data)
    );

endmodule

/* exec_checker.sv */
`timescale 1ns/10ps

module exec_checker (
    input logic        CLK,
    input logic        rst_n,
    input logic        stall,
    input logic [4:0]  wb_rd_address,
    input logic        wb_write_enable,
    input logic [31:0] wb_data
);

    // No retirement while in reset
    assert property (@(posedge CLK) !rst_n |-> !wb_write_enable)
        else $error("write enable set during reset");

    // WB slot frozen across a stalled edge
    assert property (@(posedge CLK) disable iff (!rst_n)
        stall |=> $stable(wb_data) && $stable(wb_write_enable) && $stable(wb_rd_address))
        else $error("WB outputs moved during stall");

    assert property (@(posedge CLK) disable iff (!rst_n)
        (wb_write_enable && wb_rd_address == 5'd0) |-> wb_data == '0)
        else $error("non-zero write to x0");

endmodule

/* exec_tb.sv */
`timescale 1ns/10ps

module exec_tb;

    import exec_pkg::*;

    localparam int issue_budget = 400;

    logic CLK, rst_n, stall, clear, use_pc, use_imm, rd_write_enable;
    logic [31:0] pc, imm, rs1_data, rs2_data, wb_data;
    logic [4:0] rs1_address, rs2_address, rd_address, wb_rd_address;
    logic branch_taken, wb_write_enable;
    alu_op_t alu_op;
    load_t load;
    store_t store;

    // Register file and memory as seen by decode and by the program
    logic [31:0] rf [0:31];
    logic [31:0] arch [0:31];
    logic [7:0] mem_model [0:1023];
    // Expected slots DM1, DM2, DM3, WB
    logic [31:0] s_data [0:3];
    logic [4:0] s_rd [0:3];
    logic s_we [0:3];
    logic [31:0] op_a, op_b, res;
    int seed = 74988;
    int errors = 0;
    int checks = 0;
    int mark;

    exec_top #(.mem_words(256)) exec_top_i (.*);

    bind exec_top exec_checker exec_checker_i (
        .CLK(CLK), .rst_n(rst_n), .stall(stall), .wb_rd_address(wb_rd_address),
        .wb_write_enable(wb_write_enable), .wb_data(wb_data)
    );

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    function automatic logic [31:0] alu_ref(input alu_op_t op, input logic [31:0] a, b);
        case (op)
            alu_add:    return a + b;
            alu_sub:    return a - b;
            alu_sll:    return a << b[4:0];
            alu_slt:    return {31'd0, $signed(a) < $signed(b)};
            alu_sltu:   return {31'd0, a < b};
            alu_xor:    return a ^ b;
            alu_srl:    return a >> b[4:0];
            alu_sra:    return $signed(a) >>> b[4:0];
            alu_or:     return a | b;
            alu_and:    return a & b;
            alu_pass_b: return b;
            alu_link:   return a + 32'd4;
            default:    return 32'd0;
        endcase
    endfunction

    function automatic logic branch_ref(input alu_op_t op, input logic [31:0] a, b);
        case (op)
            alu_beq:  return a == b;
            alu_bne:  return a != b;
            alu_blt:  return $signed(a) < $signed(b);
            alu_bge:  return $signed(a) >= $signed(b);
            alu_bltu: return a < b;
            alu_bgeu: return a >= b;
            default:  return 1'b0;
        endcase
    endfunction

    // Little-endian read from the byte model, then extend
    function automatic logic [31:0] load_ref(input load_t code, input logic [31:0] addr);
        logic [31:0] w;
        w = {mem_model[addr[9:0] + 3], mem_model[addr[9:0] + 2],
             mem_model[addr[9:0] + 1], mem_model[addr[9:0]]};
        case (code)
            ld_lb:   return {{24{w[7]}}, w[7:0]};
            ld_lh:   return {{16{w[15]}}, w[15:0]};
            ld_lbu:  return {24'd0, w[7:0]};
            ld_lhu:  return {16'd0, w[15:0]};
            default: return w;
        endcase
    endfunction

    ////////////////////
    // Reference pipeline
    ////////////////////
    always @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 4; i++)
                s_we[i] = 1'b0;
        end
        else if (!stall)
        begin
            if (s_we[3] && s_rd[3] != 0)
                rf[s_rd[3]] = s_data[3];
            for (int i = 3; i > 0; i--)
            begin
                s_we[i] = s_we[i-1];
                s_rd[i] = s_rd[i-1];
                s_data[i] = s_data[i-1];
            end
            s_we[0] = 1'b0;
            if (!clear)
            begin
                op_a = use_pc ? pc : arch[rs1_address];
                op_b = use_imm ? imm : arch[rs2_address];
                res = alu_ref(alu_op, op_a, op_b);
                if (load != ld_none)
                    res = load_ref(load, res);
                for (int k = 0; k < 4; k++)
                begin
                    if ((store == st_sw) || (store == st_sh && k < 2) || (store == st_sb && k < 1))
                        mem_model[res[9:0] + k] = arch[rs2_address][k*8 +: 8];
                end
                s_we[0] = rd_write_enable;
                s_rd[0] = rd_address;
                s_data[0] = res;
                if (rd_write_enable && rd_address != 0)
                    arch[rd_address] = res;
            end
        end
    end

    // Compare mid-cycle once outputs have settled
    always @(negedge CLK)
    begin
        if (rst_n)
        begin
            checks++;
            if (wb_write_enable !== s_we[3])
            begin
                errors++;
                $display("Fail at %0t: wb_write_enable expected %b actual %b",
                         $time, s_we[3], wb_write_enable);
            end
            else if (s_we[3] && (wb_rd_address !== s_rd[3] || wb_data !== s_data[3]))
            begin
                errors++;
                $display("Fail at %0t: wb_rd_address/wb_data expected %0d/%h actual %0d/%h",
                         $time, s_rd[3], s_data[3], wb_rd_address, wb_data);
            end
        end
    end

    task automatic drive(input alu_op_t op, input logic [4:0] rs1, rs2, rd, input logic we,
                         input logic upc, uimm, input logic [31:0] pcv, immv,
                         input load_t ld, input store_t st);
        logic expect_br;
        alu_op = op;
        rs1_address = rs1;
        rs2_address = rs2;
        rs1_data = rf[rs1];
        rs2_data = rf[rs2];
        rd_address = rd;
        rd_write_enable = we;
        use_pc = upc;
        use_imm = uimm;
        pc = pcv;
        imm = immv;
        load = ld;
        store = st;
        #2;
        expect_br = branch_ref(op, upc ? pcv : arch[rs1], uimm ? immv : arch[rs2]);
        if (branch_taken !== expect_br)
        begin
            errors++;
            $display("Fail at %0t: branch_taken expected %b actual %b",
                     $time, expect_br, branch_taken);
        end
    endtask

    task automatic step();
        @(posedge CLK);
        #1;
    endtask

    task automatic issue(input alu_op_t op, input logic [4:0] rs1, rs2, rd, input logic we,
                         input logic uimm, input logic [31:0] immv,
                         input load_t ld, input store_t st);
        drive(op, rs1, rs2, rd, we, 1'b0, uimm, 32'h0, immv, ld, st);
        step();
    endtask

    task automatic nops(input int n);
        repeat (n) issue(alu_add, 0, 0, 0, 1'b0, 1'b0, 0, ld_none, st_none);
    endtask

    task automatic end_test(input string name);
        $display("%s finished with %0d errors", name, errors - mark);
        mark = errors;
    endtask

    task automatic alu_test();
        repeat (20)
        begin
            issue(alu_op_t'($unsigned($random(seed)) % 10), 1 + $unsigned($random(seed)) % 31,
                  1 + $unsigned($random(seed)) % 31, 1 + $unsigned($random(seed)) % 19,
                  1'b1, $random(seed) & 1, $random(seed), ld_none, st_none);
            nops(4);
        end
        end_test("alu_test");
    endtask

    task automatic forward_test();
        for (int d = 1; d <= 4; d++)
        begin
            issue(alu_add, 1, 2, 5, 1'b1, 1'b0, 0, ld_none, st_none);
            nops(d - 1);
            issue(alu_sub, 5, 3, 6, 1'b1, 1'b0, 0, ld_none, st_none);
            issue(alu_xor, 0, 5, 7, 1'b1, 1'b0, 0, ld_none, st_none);
            nops(4);
        end
        // Back-to-back chain
        issue(alu_add, 1, 2, 8, 1'b1, 1'b0, 0, ld_none, st_none);
        issue(alu_add, 8, 3, 9, 1'b1, 1'b0, 0, ld_none, st_none);
        issue(alu_sub, 9, 8, 10, 1'b1, 1'b0, 0, ld_none, st_none);
        issue(alu_or, 10, 9, 11, 1'b1, 1'b0, 0, ld_none, st_none);
        nops(4);
        // Load of a zero word into x0 leaves its address in flight
        issue(alu_add, 0, 0, 0, 1'b0, 1'b1, 32'h80, ld_none, st_sw);
        nops(4);
        issue(alu_add, 0, 0, 0, 1'b1, 1'b1, 32'h80, ld_lw, st_none);
        // Readers of x0 must still see zero
        issue(alu_or, 0, 0, 23, 1'b1, 1'b0, 0, ld_none, st_none);
        issue(alu_or, 0, 0, 24, 1'b1, 1'b0, 0, ld_none, st_none);
        nops(4);
        end_test("forward_test");
    endtask

    task automatic branch_test();
        for (int op = 12; op <= 17; op++)
        begin
            issue(alu_op_t'(op), 1, 2, 0, 1'b0, 1'b0, 0, ld_none, st_none);
            issue(alu_op_t'(op), 3, 3, 0, 1'b0, 1'b0, 0, ld_none, st_none);
            issue(alu_op_t'(op), 4, 0, 0, 1'b0, 1'b0, 0, ld_none, st_none);
            issue(alu_op_t'(op), 0, 4, 0, 1'b0, 1'b0, 0, ld_none, st_none);
        end
        drive(alu_link, 0, 0, 12, 1'b1, 1'b1, 1'b0, 32'h100, 0, ld_none, st_none);
        step();
        issue(alu_pass_b, 0, 0, 13, 1'b1, 1'b1, 32'h12345000, ld_none, st_none);
        nops(4);
        end_test("branch_test");
    endtask

    task automatic memory_test();
        issue(alu_pass_b, 0, 0, 20, 1'b1, 1'b1, 32'h40, ld_none, st_none);
        nops(4);
        issue(alu_add, 20, 1, 0, 1'b0, 1'b1, 0, ld_none, st_sw);
        issue(alu_add, 20, 2, 0, 1'b0, 1'b1, 4, ld_none, st_sh);
        issue(alu_add, 20, 3, 0, 1'b0, 1'b1, 6, ld_none, st_sh);
        for (int k = 8; k < 12; k++)
            issue(alu_add, 20, 4 + k, 0, 1'b0, 1'b1, k, ld_none, st_sb);
        nops(5);
        for (int code = 1; code <= 5; code++)
        begin
            for (int off = 0; off < 12; off++)
            begin
                if ((code == 3 && off % 4 == 0) || ((code == 2 || code == 5) && off % 2 == 0)
                    || code == 1 || code == 4)
                    issue(alu_add, 20, 0, 21, 1'b1, 1'b1, off, load_t'(code), st_none);
            end
        end
        nops(4);
        end_test("memory_test");
    endtask

    task automatic clear_stall_test();
        clear = 1'b1;
        issue(alu_add, 1, 2, 14, 1'b1, 1'b0, 0, ld_none, st_none);
        issue(alu_add, 20, 9, 0, 1'b0, 1'b1, 0, ld_none, st_sw);
        clear = 1'b0;
        nops(4);
        issue(alu_add, 20, 0, 22, 1'b1, 1'b1, 0, ld_lw, st_none);
        issue(alu_add, 1, 2, 15, 1'b1, 1'b0, 0, ld_none, st_none);
        stall = 1'b1;
        drive(alu_sub, 15, 3, 16, 1'b1, 1'b0, 1'b0, 0, 0, ld_none, st_none);
        repeat (5) step();
        stall = 1'b0;
        step();
        issue(alu_and, 16, 15, 17, 1'b1, 1'b0, 0, ld_none, st_none);
        nops(5);
        end_test("clear_stall_test");
    endtask

    initial
    begin
        #((issue_budget + 100) * 8);
        $display("Watchdog expired before the tests completed");
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        rst_n = 1'b0;
        stall = 1'b0;
        clear = 1'b0;
        rf[0] = '0;
        arch[0] = '0;
        for (int i = 1; i < 32; i++)
        begin
            rf[i] = $random(seed);
            arch[i] = rf[i];
        end
        drive(alu_add, 0, 0, 0, 1'b0, 1'b0, 1'b0, 0, 0, ld_none, st_none);
        mark = 0;
        repeat (16) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        alu_test();
        forward_test();
        branch_test();
        memory_test();
        clear_stall_test();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* filelist.f */
exec_pkg.sv
forward_unit.sv
alu.sv
execution_stage.sv
mem_pipeline.sv
exec_top.sv
exec_checker.sv
exec_tb.sv
